//--- memory_game.f
+incdir+tests
hdl/memory_game_pkg.sv
hdl/game_control.sv
hdl/level_source.sv
hdl/note_buffer.sv
hdl/note_player.sv
hdl/response_checker.sv
hdl/memory_game.sv
tests/memory_game_tb.sv

//--- Makefile
VERILATOR    = verilator
TOP          = memory_game_tb
FILELIST     = memory_game.f
OBJ_DIR      = obj_dir
COMMON_FLAGS = --timing --timescale 1ns/1ps
LINT_FLAGS   = --lint-only $(COMMON_FLAGS)
SIM_FLAGS    = --binary $(COMMON_FLAGS) -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/memory_game_checks.svh
task automatic check_state(input string name, input game_state_e got, input game_state_e exp);
    if (got !== exp)
        stop_with_failure($sformatf("ERR %0t %s expected %s got %s",
                                    $time, name, exp.name(), got.name()));
endtask

task automatic check_level(input string name, input level_t got, input level_t exp);
    if (got !== exp)
        stop_with_failure($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp, got));
endtask

task automatic check_note(input string name, input note_t got, input note_t exp);
    if (got !== exp)
        stop_with_failure($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, got));
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
        stop_with_failure($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp, got));
endtask

// drive and sample just after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic wait_for_state(input game_state_e target, input int limit);
    int waited;
    waited = 0;
    while (status.state != target)
    begin
        if (waited >= limit)
            stop_with_failure($sformatf("timed out after %0d cycles waiting for state %s",
                                        limit, target.name()));
        next_cycle();
        waited++;
    end
endtask

// random gap, then a new key vector, then wait for the check loop to finish
task automatic change_keys(input note_t value);
    int unsigned gap;
    gap = 1 + ($urandom % 4);
    repeat (gap) next_cycle();
    keys = value;
    wait_for_state(ST_ADVANCE, 20);
endtask

task automatic replay_recorded();
    foreach (played_notes[i])
    begin
        change_keys(played_notes[i]);
        change_keys(4'b0000);
    end
endtask

//--- tests/memory_game_tb.sv
`timescale 1ns/1ps

module memory_game_tb;
    import memory_game_pkg::*;

    localparam int NOTE_TICKS = 8;
    localparam int WIN_TICKS  = 20;

    // notes of levels 1 and 2
    localparam note_t SCALE_NOTES [4] = '{4'd1, 4'd2, 4'd4, 4'd8};

    logic         clk;
    logic         load;
    logic         start_game;
    level_t       level_select;
    note_t        keys;
    note_t        note_leds;
    game_status_t status;

    note_t        played_notes[$];
    int           played_lens[$];

    memory_game #(
        .NOTE_TICKS (NOTE_TICKS),
        .WIN_TICKS  (WIN_TICKS)
    ) dut_i (
        .clk          (clk),
        .load         (load),
        .start_game   (start_game),
        .level_select (level_select),
        .keys         (keys),
        .note_leds    (note_leds),
        .status       (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first failure");
    endtask

    `include "memory_game_checks.svh"

    task automatic apply_reset(input level_t sel);
        load         = 1'b1;
        start_game   = 1'b0;
        level_select = sel;
        keys         = 4'b0000;
        repeat (16) next_cycle();
        load = 1'b0;
    endtask

    task automatic start_round();
        start_game = 1'b1;
        next_cycle();
        start_game = 1'b0;
        wait_for_state(ST_LOAD, 5);
    endtask

    // collect the non-zero LED runs shown while in ST_PLAY
    task automatic record_playback();
        note_t cur;
        int    run;
        int    waited;
        played_notes.delete();
        played_lens.delete();
        wait_for_state(ST_PLAY, 20);
        cur    = note_leds;
        run    = 1;
        waited = 0;
        while (status.state == ST_PLAY)
        begin
            if (waited >= 400)
                stop_with_failure("playback did not end within 400 cycles");
            next_cycle();
            waited++;
            if (note_leds == cur)
                run++;
            else
            begin
                if (cur != 4'b0000)
                begin
                    played_notes.push_back(cur);
                    played_lens.push_back(run);
                end
                cur = note_leds;
                run = 1;
            end
        end
        if (cur != 4'b0000)
        begin
            played_notes.push_back(cur);
            played_lens.push_back(run);
        end
    endtask

    task automatic check_scale_playback();
        record_playback();
        check_count("playback note count", played_notes.size(), 4);
        foreach (SCALE_NOTES[i])
        begin
            check_note("note_leds", played_notes[i], SCALE_NOTES[i]);
            check_count("note period", played_lens[i], NOTE_TICKS);
        end
        wait_for_state(ST_WAIT, 4);
    endtask

    task automatic check_win_pause();
        int cycles;
        cycles = 0;
        wait_for_state(ST_WON, 10);
        while (status.state == ST_WON)
        begin
            if (cycles > 2 * WIN_TICKS)
                stop_with_failure("win pause did not end");
            cycles++;
            next_cycle();
        end
        check_count("win pause cycles", cycles, WIN_TICKS);
    endtask

    task automatic reset_and_start();
        apply_reset(4'd0);
        check_state("status.state", status.state, ST_IDLE);
        check_level("status.level", status.level, 4'd0);
        check_note("note_leds", note_leds, 4'b0000);
        keys = 4'b0101;
        next_cycle();
        check_note("note_leds", note_leds, 4'b0101);
        keys = 4'b0000;
        next_cycle();
        check_note("note_leds", note_leds, 4'b0000);
        start_round();
        check_level("status.level", status.level, 4'd1);
    endtask

    task automatic replay_and_win();
        replay_recorded();
        check_win_pause();
        wait_for_state(ST_LOAD, 5);
        check_level("status.level", status.level, 4'd2);
        check_scale_playback();
    endtask

    // first slot of level 2 is key 1
    task automatic wrong_key_loses();
        change_keys(4'd2);
        wait_for_state(ST_LOST, 3);
        keys = 4'b0000;
        repeat (50)
        begin
            next_cycle();
            check_state("status.state", status.state, ST_LOST);
        end
    endtask

    task automatic random_level_round();
        apply_reset(4'd4);
        check_level("status.level", status.level, 4'd4);
        start_round();
        check_level("status.level", status.level, 4'd5);
        record_playback();
        check_count("playback note count", played_notes.size(), 6);
        foreach (played_notes[i])
        begin
            if (!$onehot(played_notes[i]))
                stop_with_failure($sformatf("played note %b is not a single key",
                                            played_notes[i]));
            check_count("note period", played_lens[i], NOTE_TICKS);
        end
        wait_for_state(ST_WAIT, 4);
        replay_recorded();
        check_win_pause();
        wait_for_state(ST_LOAD, 5);
        check_level("status.level", status.level, 4'd6);
    endtask

    initial
    begin
        void'($urandom(32'h5261));
        load         = 1'b1;
        start_game   = 1'b0;
        level_select = 4'd0;
        keys         = 4'b0000;
        reset_and_start();
        check_scale_playback();
        replay_and_win();
        wrong_key_loses();
        random_level_round();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- hdl/memory_game.sv
`timescale 1ns/1ps

module memory_game #(
    parameter int NOTE_TICKS = 25_000_000,
    parameter int WIN_TICKS  = 50_000_000
) (
    input  logic                         clk,
    input  logic                         load,
    input  logic                         start_game,
    input  memory_game_pkg::level_t       level_select,
    input  memory_game_pkg::note_t        keys,
    output memory_game_pkg::note_t        note_leds,
    output memory_game_pkg::game_status_t status
);
    import memory_game_pkg::*;

    game_state_e state;
    level_t      level;
    seq_desc_t   seq;
    note_t       slot;
    logic        empty;
    logic        level_up;
    logic        seq_load;
    logic        play_en;
    logic        check_en;
    logic        advance_en;
    logic        key_event;
    logic        mistake;
    logic        play_step;
    logic        check_step;

    game_control #(
        .WIN_TICKS (WIN_TICKS)
    ) u_control (
        .clk        (clk),
        .load       (load),
        .start_game (start_game),
        .empty      (empty),
        .key_event  (key_event),
        .mistake    (mistake),
        .state      (state),
        .level_up   (level_up),
        .seq_load   (seq_load),
        .play_en    (play_en),
        .check_en   (check_en),
        .advance_en (advance_en)
    );

    level_source u_source (
        .clk          (clk),
        .load         (load),
        .level_select (level_select),
        .level_up     (level_up),
        .level        (level),
        .seq          (seq)
    );

    // playback and response never step in the same state
    note_buffer u_buffer (
        .clk      (clk),
        .load     (load),
        .seq_load (seq_load),
        .seq      (seq),
        .step     (play_step || check_step),
        .slot     (slot),
        .empty    (empty)
    );

    note_player #(
        .NOTE_TICKS (NOTE_TICKS)
    ) u_player (
        .clk     (clk),
        .load    (load),
        .play_en (play_en),
        .step    (play_step)
    );

    response_checker u_checker (
        .clk        (clk),
        .load       (load),
        .keys       (keys),
        .slot       (slot),
        .check_en   (check_en),
        .advance_en (advance_en),
        .key_event  (key_event),
        .mistake    (mistake),
        .step       (check_step)
    );

    // show the sequence during playback, echo the keys otherwise
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            note_leds <= '0;
        else if (state == ST_PLAY)
            note_leds <= slot;
        else
            note_leds <= keys;
    end

    assign status.state = state;
    assign status.level = level;

endmodule

//--- hdl/response_checker.sv
`timescale 1ns/1ps

module response_checker (
    input  logic                  clk,
    input  logic                  load,
    input  memory_game_pkg::note_t keys,
    input  memory_game_pkg::note_t slot,
    input  logic                  check_en,
    input  logic                  advance_en,
    output logic                  key_event,
    output logic                  mistake,
    output logic                  step
);
    import memory_game_pkg::*;

    note_t keys_q;
    note_t last_keys;

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            keys_q <= '0;
        else
            keys_q <= keys;
    end

    // last_keys only moves on a check, so a change during
    // check or advance is still pending afterwards
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            last_keys <= '0;
            mistake   <= 1'b0;
        end
        else if (check_en)
        begin
            last_keys <= keys_q;
            mistake   <= (keys_q != slot);
        end
    end

    assign key_event = (keys_q != last_keys);
    assign step      = advance_en;

endmodule

//--- hdl/note_player.sv
`timescale 1ns/1ps

module note_player #(
    parameter int NOTE_TICKS = 25_000_000
) (
    input  logic clk,
    input  logic load,
    input  logic play_en,
    output logic step
);

    localparam logic [31:0] TICK_LAST = 32'(NOTE_TICKS - 1);

    logic [31:0] tick_cnt;

    // held at the top of the period outside playback
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            tick_cnt <= TICK_LAST;
        else if (!play_en || tick_cnt == '0)
            tick_cnt <= TICK_LAST;
        else
            tick_cnt <= tick_cnt - 1'b1;
    end

    assign step = play_en && (tick_cnt == '0);

endmodule

//--- hdl/note_buffer.sv
`timescale 1ns/1ps

module note_buffer (
    input  logic                      clk,
    input  logic                      load,
    input  logic                      seq_load,
    input  memory_game_pkg::seq_desc_t seq,
    input  logic                      step,
    output memory_game_pkg::note_t     slot,
    output logic                      empty
);
    import memory_game_pkg::*;

    seq_t        shift_q;
    slot_count_t remaining;
    logic        advance;

    // a step past the last slot does nothing
    assign advance = step && !empty;

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            shift_q <= '0;
        else if (seq_load)
            shift_q <= seq.notes;
        else if (advance)
            shift_q <= shift_q << $bits(note_t);
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            remaining <= '0;
        else if (seq_load)
            remaining <= seq.length;
        else if (advance)
            remaining <= remaining - 1'b1;
    end

    assign slot  = shift_q[$bits(seq_t)-1 -: $bits(note_t)];
    assign empty = (remaining == '0);

endmodule

//--- hdl/level_source.sv
`timescale 1ns/1ps

module level_source (
    input  logic                      clk,
    input  logic                      load,
    input  memory_game_pkg::level_t    level_select,
    input  logic                      level_up,
    output memory_game_pkg::level_t    level,
    output memory_game_pkg::seq_desc_t seq
);
    import memory_game_pkg::*;

    // fixed levels with an empty slot after each note
    localparam seq_t SEQ_SCALE = 48'h1020_4080_0000;
    localparam seq_t SEQ_ECHO  = 48'h1020_2010_1000;
    localparam seq_t SEQ_DOWN  = 48'h4020_1040_2010;

    logic [MAX_SLOTS-1:0] rand_cnt;
    seq_t                 next_rand;
    seq_t                 rand_seq;

    function automatic note_t to_note(input logic [1:0] sel);
        return note_t'(4'b0001 << sel);
    endfunction

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            level <= level_select;
        else if (level_up)
            level <= level + 1'b1;
    end

    // free-running counter sampled on each level up
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            rand_cnt <= '0;
        else
            rand_cnt <= rand_cnt + 1'b1;
    end

    always_comb
    begin
        next_rand = '0;
        for (int i = 0; i < MAX_SLOTS / 2; i++)
        begin
            next_rand[4*(MAX_SLOTS-1-2*i) +: 4] = to_note(rand_cnt[2*i +: 2]);
        end
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            rand_seq <= '0;
        else if (level_up)
            rand_seq <= next_rand;
    end

    always_comb
    begin
        case (level)
            4'd0:
            begin
                seq.notes  = '0;
                seq.length = 4'd0;
            end
            4'd1, 4'd2:
            begin
                seq.notes  = SEQ_SCALE;
                seq.length = 4'd8;
            end
            4'd3:
            begin
                seq.notes  = SEQ_ECHO;
                seq.length = 4'd10;
            end
            4'd4:
            begin
                seq.notes  = SEQ_DOWN;
                seq.length = 4'd12;
            end
            default:
            begin
                seq.notes  = rand_seq;
                seq.length = 4'd12;
            end
        endcase
    end

endmodule

//--- hdl/game_control.sv
`timescale 1ns/1ps

module game_control #(
    parameter int WIN_TICKS = 50_000_000
) (
    input  logic                        clk,
    input  logic                        load,
    input  logic                        start_game,
    input  logic                        empty,
    input  logic                        key_event,
    input  logic                        mistake,
    output memory_game_pkg::game_state_e state,
    output logic                        level_up,
    output logic                        seq_load,
    output logic                        play_en,
    output logic                        check_en,
    output logic                        advance_en
);
    import memory_game_pkg::*;

    localparam logic [31:0] WIN_LAST = 32'(WIN_TICKS - 1);

    game_state_e next_state;
    logic [31:0] win_cnt;
    logic        win_done;

    assign win_done = (win_cnt == WIN_LAST);

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (start_game)
                    next_state = ST_LEVEL_UP;
            ST_LEVEL_UP:
                next_state = ST_LOAD;
            ST_LOAD:
                next_state = ST_PLAY;
            // player has stepped through every slot
            ST_PLAY:
                if (empty)
                    next_state = ST_RELOAD;
            ST_RELOAD:
                next_state = ST_WAIT;
            ST_WAIT:
                if (empty)
                    next_state = ST_WON;
                else if (key_event)
                    next_state = ST_CHECK;
            ST_CHECK:
                next_state = ST_ADVANCE;
            // mistake was registered at the end of the check cycle
            ST_ADVANCE:
                next_state = mistake ? ST_LOST : ST_WAIT;
            ST_WON:
                if (win_done)
                    next_state = ST_LEVEL_UP;
            ST_LOST:
                next_state = ST_LOST;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    // win pause counter only runs in ST_WON
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            win_cnt <= '0;
        else if (state != ST_WON || win_done)
            win_cnt <= '0;
        else
            win_cnt <= win_cnt + 1'b1;
    end

    assign level_up   = (state == ST_LEVEL_UP);
    assign seq_load   = (state == ST_LOAD) || (state == ST_RELOAD);
    assign play_en    = (state == ST_PLAY);
    assign check_en   = (state == ST_CHECK);
    assign advance_en = (state == ST_ADVANCE);

endmodule

//--- hdl/memory_game_pkg.sv
package memory_game_pkg;

    // slots per level
    localparam int MAX_SLOTS = 12;

    // one-hot note or all zero for released keys
    typedef logic [3:0] note_t;

    // slot 0 in the top nibble
    typedef logic [4*MAX_SLOTS-1:0] seq_t;

    typedef logic [3:0] slot_count_t;
    typedef logic [3:0] level_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LEVEL_UP,
        ST_LOAD,
        ST_PLAY,
        ST_RELOAD,
        ST_WAIT,
        ST_CHECK,
        ST_ADVANCE,
        ST_WON,
        ST_LOST
    } game_state_e;

    typedef struct packed {
        game_state_e state;
        level_t      level;
    } game_status_t;

    // sequence plus the number of valid slots
    typedef struct packed {
        seq_t        notes;
        slot_count_t length;
    } seq_desc_t;

endpackage
